// ==== filelist.f ====
src/rv_isa_pkg.sv
src/decode_pkg.sv
src/inst_capture.sv
src/inst_decoder.sv
src/imm_gen.sv
src/decode_issue.sv
src/decode_stage.sv
bench/decode_stage_asserts.sv
bench/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - src/rv_isa_pkg.sv
  - src/decode_pkg.sv
  - src/inst_capture.sv
  - src/inst_decoder.sv
  - src/imm_gen.sv
  - src/decode_issue.sv
  - src/decode_stage.sv
  - target: test
    files:
      - bench/decode_stage_asserts.sv
      - bench/decode_stage_tb.sv

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/100ps

module decode_stage_tb;

        import rv_isa_pkg::*;
        import decode_pkg::*;

        localparam int n_inst    = 400;
        localparam int max_cycle = 8 + n_inst * 3 + 20;

        logic        clk;
        logic        rst;
        logic        inst_valid;
        logic [31:0] inst_pc;
        logic [31:0] inst;
        logic        out_valid;
        issue_t      out;

        integer      seed;
        integer      cycles;
        issue_t      exp_q[$];

        // kinds indexed by funct3
        rv_op_e r_tab [8] = '{k_add, k_sll, k_slt, k_sltu, k_xor, k_srl, k_or, k_and};
        rv_op_e m_tab [8] = '{k_mul, k_mulh, k_mulhsu, k_mulhu, k_div, k_divu, k_rem, k_remu};
        rv_op_e i_tab [8] = '{k_addi, k_slli, k_slti, k_sltiu, k_xori, k_srli, k_ori, k_andi};
        rv_op_e l_tab [8] = '{k_lb, k_lh, k_lw, k_illegal, k_lbu, k_lhu, k_illegal, k_illegal};
        rv_op_e s_tab [8] = '{k_sb, k_sh, k_sw, k_illegal, k_illegal, k_illegal, k_illegal,
                              k_illegal};
        rv_op_e b_tab [8] = '{k_beq, k_bne, k_illegal, k_illegal, k_blt, k_bge, k_bltu, k_bgeu};

        decode_stage #(.en_mul(1'b1)) uut (
                .clk        (clk),
                .rst        (rst),
                .inst_valid (inst_valid),
                .inst_pc    (inst_pc),
                .inst       (inst),
                .out_valid  (out_valid),
                .out        (out)
        );

        always #10 clk = ~clk;

        task automatic stop_run(input string why);
                $display("%s", why);
                $display("Verification failed");
                $fatal(1, "simulation stopped on first error");
        endtask

        task automatic check(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
                if (got !== exp)
                        stop_run($sformatf("Error: %s expected %h got %h", name, exp, got));
        endtask

        ////////////////////////////////////////
        // expected packet
        ////////////////////////////////////////

        function automatic issue_t expect_issue(input logic [31:0] pc, input logic [31:0] w);
                issue_t             r;
                logic [6:0]         f7;
                logic [2:0]         f3;
                logic signed [31:0] hi;
                f7 = w[31:25];
                f3 = w[14:12];
                r  = '0;
                r.pc      = pc;
                r.dec.rd  = w[11:7];
                r.dec.rs1 = w[19:15];
                r.dec.rs2 = w[24:20];
                case (w[6:0])
                        7'h33: r.dec.op = (f7 == 7'h00) ? r_tab[f3] :
                                          (f7 == 7'h01) ? m_tab[f3] :
                                          (f7 == 7'h20 && f3 == 3'h0) ? k_sub :
                                          (f7 == 7'h20 && f3 == 3'h5) ? k_sra : k_illegal;
                        7'h13: begin
                                r.dec.op = i_tab[f3];
                                // shift amount leaves funct7 to pick the shift
                                if (f3 == 3'h5 && f7 == 7'h20)
                                        r.dec.op = k_srai;
                                else if ((f3 == 3'h1 || f3 == 3'h5) && f7 != 7'h00)
                                        r.dec.op = k_illegal;
                        end
                        7'h03: r.dec.op = l_tab[f3];
                        7'h23: r.dec.op = s_tab[f3];
                        7'h63: r.dec.op = b_tab[f3];
                        7'h67: r.dec.op = (f3 == 3'h0) ? k_jalr : k_illegal;
                        7'h37: r.dec.op = k_lui;
                        7'h17: r.dec.op = k_auipc;
                        7'h6f: r.dec.op = k_jal;
                        default: r.dec.op = k_illegal;
                endcase
                case (w[6:0])
                        7'h13, 7'h03, 7'h67: r.dec.fmt = fmt_i;
                        7'h23: r.dec.fmt = fmt_s;
                        7'h63: r.dec.fmt = fmt_b;
                        7'h37, 7'h17: r.dec.fmt = fmt_u;
                        7'h6f: r.dec.fmt = fmt_j;
                        default: r.dec.fmt = fmt_none;
                endcase
                r.dec.illegal = (r.dec.op == k_illegal);
                if (r.dec.illegal)
                        r.dec.fmt = fmt_none;
                // upper bits carry the sign of bit 31
                hi = $signed(w) >>> 20;
                case (r.dec.fmt)
                        fmt_i: r.dec.imm = hi;
                        fmt_s: r.dec.imm = {hi[31:5], w[11:7]};
                        fmt_b: r.dec.imm = {hi[31:12], w[7], w[30:25], w[11:8], 1'b0};
                        fmt_u: r.dec.imm = {w[31:12], 12'h000};
                        fmt_j: r.dec.imm = {hi[31:20], w[19:12], w[20], w[30:21], 1'b0};
                        default: r.dec.imm = '0;
                endcase
                if (r.dec.fmt == fmt_b || r.dec.fmt == fmt_j || r.dec.op == k_auipc)
                        r.target = pc + r.dec.imm;
                else
                        r.target = pc + 32'd4;
                r.rd_we = !r.dec.illegal && r.dec.fmt != fmt_s && r.dec.fmt != fmt_b &&
                          r.dec.rd != 5'd0;
                return r;
        endfunction

        ////////////////////////////////////////
        // random instruction words
        ////////////////////////////////////////

        task automatic make_inst(output logic [31:0] w);
                logic [2:0] f3;
                int         pick;
                w  = $random(seed);
                f3 = w[14:12];
                if ({$random(seed)} % 8 == 0) begin
                        // raw word, or a known opcode with unchecked funct bits
                        pick = {$random(seed)} % 4;
                        if (pick == 1)
                                w[6:0] = 7'h33;
                        else if (pick == 2)
                                w[6:0] = 7'h13;
                        else if (pick == 3)
                                w[6:0] = 7'h03;
                end else begin
                        case ({$random(seed)} % 10)
                                0: begin
                                        w[6:0]   = 7'h33;
                                        w[31:25] = (w[30] && (f3 == 3'h0 || f3 == 3'h5)) ?
                                                   7'h20 : 7'h00;
                                end
                                1: begin
                                        w[6:0]   = 7'h33;
                                        w[31:25] = 7'h01;
                                end
                                2: begin
                                        w[6:0] = 7'h13;
                                        if (f3 == 3'h1)
                                                w[31:25] = 7'h00;
                                        if (f3 == 3'h5)
                                                w[31:25] = w[30] ? 7'h20 : 7'h00;
                                end
                                3: begin
                                        w[6:0]   = 7'h03;
                                        w[14:12] = (f3 == 3'h3 || f3[2:1] == 2'b11) ? 3'h2 : f3;
                                end
                                4: begin
                                        w[6:0]   = 7'h23;
                                        w[14:12] = f3 % 3;
                                end
                                5: begin
                                        // funct3 2 and 3 move up to bltu and bgeu
                                        w[6:0] = 7'h63;
                                        w[14]  = w[14] | w[13];
                                end
                                6: begin
                                        w[6:0]   = 7'h67;
                                        w[14:12] = 3'h0;
                                end
                                7: w[6:0] = 7'h37;
                                8: w[6:0] = 7'h17;
                                default: w[6:0] = 7'h6f;
                        endcase
                end
        endtask

        ////////////////////////////////////////
        // stimulus
        ////////////////////////////////////////

        initial begin
                logic [31:0] w;
                logic [31:0] pc;
                int          gap;
                seed       = 75138;
                clk        = 1'b0;
                rst        = 1'b1;
                inst_valid = 1'b0;
                inst_pc    = '0;
                inst       = '0;
                repeat (8) @(posedge clk);
                #2 rst = 1'b0;
                for (int i = 0; i < n_inst; i++) begin
                        make_inst(w);
                        pc      = $random(seed);
                        pc[1:0] = 2'b00;
                        gap     = {$random(seed)} % 3;
                        @(posedge clk);
                        #2;
                        inst_valid = 1'b1;
                        inst_pc    = pc;
                        inst       = w;
                        exp_q.push_back(expect_issue(pc, w));
                        repeat (gap) begin
                                @(posedge clk);
                                #2 inst_valid = 1'b0;
                        end
                end
                @(posedge clk);
                #2 inst_valid = 1'b0;
                // two cycles for the last packet and an idle tail for stray outputs
                repeat (5) @(posedge clk);
                if (exp_q.size() != 0) begin
                        stop_run("expected packets left over at the end of the run");
                end else begin
                        $display("Verification passed");
                        $finish;
                end
        end

        // outputs are stable at the falling edge
        always @(negedge clk) begin : compare
                issue_t e;
                if (!rst && out_valid) begin
                        if (exp_q.size() == 0) begin
                                stop_run("an output appeared with no instruction pending");
                        end else begin
                                e = exp_q.pop_front();
                                check("out.dec.op", out.dec.op, e.dec.op);
                                check("out.dec.rd", out.dec.rd, e.dec.rd);
                                check("out.dec.rs1", out.dec.rs1, e.dec.rs1);
                                check("out.dec.rs2", out.dec.rs2, e.dec.rs2);
                                check("out.dec.fmt", out.dec.fmt, e.dec.fmt);
                                check("out.dec.imm", out.dec.imm, e.dec.imm);
                                check("out.dec.illegal", out.dec.illegal, e.dec.illegal);
                                check("out.pc", out.pc, e.pc);
                                check("out.target", out.target, e.target);
                                check("out.rd_we", out.rd_we, e.rd_we);
                        end
                end
        end

        initial begin
                cycles = 0;
                while (cycles < max_cycle) begin
                        @(posedge clk);
                        cycles = cycles + 1;
                end
                stop_run("timeout, outputs stopped before every instruction came out");
        end

endmodule

// ==== bench/decode_stage_asserts.sv ====
`timescale 1ns/100ps

module decode_stage_asserts (
        input logic               clk,
        input logic               rst,
        input logic               inst_valid,
        input logic               out_valid,
        input decode_pkg::issue_t out
);

        ////////////////////////////////////////
        // strobe timing
        ////////////////////////////////////////

        // nothing leaves the stage while reset is held
        a_quiet_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
                else $error("out_valid high during reset");

        // capture plus issue register
        a_two_cycle_latency: assert property (@(posedge clk) disable iff (rst)
                inst_valid |-> ##2 out_valid)
                else $error("out_valid missing two cycles after inst_valid");

        ////////////////////////////////////////
        // packet sanity
        ////////////////////////////////////////

        a_no_illegal_write: assert property (@(posedge clk) disable iff (rst)
                (out_valid && out.rd_we) |-> !out.dec.illegal)
                else $error("register write enabled for an illegal instruction");

endmodule

bind decode_stage decode_stage_asserts u_asserts (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .out_valid  (out_valid),
        .out        (out)
);

// ==== src/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage #(
        parameter bit en_mul = 1'b1
) (
        input  logic                        clk,
        input  logic                        rst,
        input  logic                        inst_valid,
        input  logic [rv_isa_pkg::xlen-1:0] inst_pc,
        input  logic [rv_isa_pkg::xlen-1:0] inst,
        output logic                        out_valid,
        output decode_pkg::issue_t          out
);

        import rv_isa_pkg::*;
        import decode_pkg::*;

        logic            cap_valid;
        fetch_t          cap;
        decoded_t        dec_raw;
        decoded_t        dec;
        logic [xlen-1:0] imm;

        inst_capture u_capture (
                .clk        (clk),
                .rst        (rst),
                .inst_valid (inst_valid),
                .inst_pc    (inst_pc),
                .inst       (inst),
                .cap_valid  (cap_valid),
                .cap        (cap)
        );

        inst_decoder #(.en_mul(en_mul)) u_decoder (
                .cap (cap),
                .dec (dec_raw)
        );

        imm_gen u_imm_gen (
                .inst (cap.inst),
                .fmt  (dec_raw.fmt),
                .imm  (imm)
        );

        // decoded fields with the immediate merged in
        assign dec = '{op: dec_raw.op, rd: dec_raw.rd, rs1: dec_raw.rs1, rs2: dec_raw.rs2,
                       fmt: dec_raw.fmt, imm: imm, illegal: dec_raw.illegal};

        decode_issue u_issue (
                .clk       (clk),
                .rst       (rst),
                .cap_valid (cap_valid),
                .pc        (cap.pc),
                .dec       (dec),
                .out_valid (out_valid),
                .out       (out)
        );

endmodule

// ==== src/decode_issue.sv ====
`timescale 1ns/100ps

module decode_issue (
        input  logic                        clk,
        input  logic                        rst,
        input  logic                        cap_valid,
        input  logic [rv_isa_pkg::xlen-1:0] pc,
        input  decode_pkg::decoded_t        dec,
        output logic                        out_valid,
        output decode_pkg::issue_t          out
);

        import rv_isa_pkg::*;

        logic            is_branch;
        logic            is_store;
        logic            pc_rel;
        logic [xlen-1:0] target;
        logic            rd_we;

        ////////////////////////////////////////
        // target and write enable
        ////////////////////////////////////////

        assign is_branch = dec.op inside {k_beq, k_bne, k_blt, k_bge, k_bltu, k_bgeu};
        assign is_store  = dec.op inside {k_sb, k_sh, k_sw};
        assign pc_rel    = is_branch || (dec.op == k_jal) || (dec.op == k_auipc);

        // jalr needs rs1, so it falls through to pc + 4
        assign target = pc_rel ? pc + dec.imm : pc + 32'd4;

        // x0 is never written
        assign rd_we = !dec.illegal && !is_branch && !is_store && (dec.rd != '0);

        always_ff @(posedge clk) begin
                if (rst) begin
                        out_valid <= 1'b0;
                        out       <= '0;
                end else begin
                        out_valid <= cap_valid;
                        if (cap_valid) begin
                                out.dec    <= dec;
                                out.pc     <= pc;
                                out.target <= target;
                                out.rd_we  <= rd_we;
                        end
                end
        end

endmodule

// ==== src/imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen (
        input  logic [rv_isa_pkg::xlen-1:0] inst,
        input  decode_pkg::imm_fmt_e        fmt,
        output logic [rv_isa_pkg::xlen-1:0] imm
);

        import decode_pkg::*;

        // all forms sign extend from bit 31
        always_comb begin
                case (fmt)
                        fmt_i: begin
                                imm = {{20{inst[31]}}, inst[31:20]};
                        end
                        fmt_s: begin
                                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                        end
                        fmt_b: begin
                                // halfword offset
                                imm = {{19{inst[31]}}, inst[31], inst[7],
                                       inst[30:25], inst[11:8], 1'b0};
                        end
                        fmt_u: begin
                                imm = {inst[31:12], 12'h000};
                        end
                        fmt_j: begin
                                imm = {{11{inst[31]}}, inst[31], inst[19:12],
                                       inst[20], inst[30:21], 1'b0};
                        end
                        default: begin
                                imm = '0;
                        end
                endcase
        end

endmodule

// ==== src/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder #(
        parameter bit en_mul = 1'b1
) (
        input  decode_pkg::fetch_t   cap,
        output decode_pkg::decoded_t dec
);

        import rv_isa_pkg::*;
        import decode_pkg::*;

        opcode_e    opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        rv_op_e     kind;
        imm_fmt_e   fmt;

        ////////////////////////////////////////
        // field split
        ////////////////////////////////////////

        assign opcode = opcode_e'(cap.inst[6:0]);
        assign funct3 = cap.inst[14:12];
        assign funct7 = cap.inst[31:25];

        ////////////////////////////////////////
        // classification
        ////////////////////////////////////////

        always_comb begin
                kind = k_illegal;
                fmt  = fmt_none;
                case (opcode)
                        op_r: begin
                                case ({funct7, funct3})
                                        {7'h00, 3'h0}: kind = k_add;
                                        {7'h20, 3'h0}: kind = k_sub;
                                        {7'h00, 3'h1}: kind = k_sll;
                                        {7'h00, 3'h2}: kind = k_slt;
                                        {7'h00, 3'h3}: kind = k_sltu;
                                        {7'h00, 3'h4}: kind = k_xor;
                                        {7'h00, 3'h5}: kind = k_srl;
                                        {7'h20, 3'h5}: kind = k_sra;
                                        {7'h00, 3'h6}: kind = k_or;
                                        {7'h00, 3'h7}: kind = k_and;
                                        // M group, only when multiply is built in
                                        {7'h01, 3'h0}: kind = en_mul ? k_mul : k_illegal;
                                        {7'h01, 3'h1}: kind = en_mul ? k_mulh : k_illegal;
                                        {7'h01, 3'h2}: kind = en_mul ? k_mulhsu : k_illegal;
                                        {7'h01, 3'h3}: kind = en_mul ? k_mulhu : k_illegal;
                                        {7'h01, 3'h4}: kind = en_mul ? k_div : k_illegal;
                                        {7'h01, 3'h5}: kind = en_mul ? k_divu : k_illegal;
                                        {7'h01, 3'h6}: kind = en_mul ? k_rem : k_illegal;
                                        {7'h01, 3'h7}: kind = en_mul ? k_remu : k_illegal;
                                        default:       kind = k_illegal;
                                endcase
                        end
                        op_imm: begin
                                fmt = fmt_i;
                                case (funct3)
                                        3'h0: kind = k_addi;
                                        3'h1: kind = (funct7 == 7'h00) ? k_slli : k_illegal;
                                        3'h2: kind = k_slti;
                                        3'h3: kind = k_sltiu;
                                        3'h4: kind = k_xori;
                                        3'h5: begin
                                                // shamt sits below the funct7 bits
                                                if (funct7 == 7'h00)
                                                        kind = k_srli;
                                                else if (funct7 == 7'h20)
                                                        kind = k_srai;
                                        end
                                        3'h6: kind = k_ori;
                                        default: kind = k_andi;
                                endcase
                        end
                        op_load: begin
                                fmt = fmt_i;
                                case (funct3)
                                        3'h0: kind = k_lb;
                                        3'h1: kind = k_lh;
                                        3'h2: kind = k_lw;
                                        3'h4: kind = k_lbu;
                                        3'h5: kind = k_lhu;
                                        default: kind = k_illegal;
                                endcase
                        end
                        op_store: begin
                                fmt = fmt_s;
                                case (funct3)
                                        3'h0: kind = k_sb;
                                        3'h1: kind = k_sh;
                                        3'h2: kind = k_sw;
                                        default: kind = k_illegal;
                                endcase
                        end
                        op_branch: begin
                                fmt = fmt_b;
                                case (funct3)
                                        3'h0: kind = k_beq;
                                        3'h1: kind = k_bne;
                                        3'h4: kind = k_blt;
                                        3'h5: kind = k_bge;
                                        3'h6: kind = k_bltu;
                                        3'h7: kind = k_bgeu;
                                        default: kind = k_illegal;
                                endcase
                        end
                        op_jalr: begin
                                fmt  = fmt_i;
                                kind = (funct3 == 3'h0) ? k_jalr : k_illegal;
                        end
                        op_lui: begin
                                fmt  = fmt_u;
                                kind = k_lui;
                        end
                        op_auipc: begin
                                fmt  = fmt_u;
                                kind = k_auipc;
                        end
                        op_jal: begin
                                fmt  = fmt_j;
                                kind = k_jal;
                        end
                        default: kind = k_illegal;
                endcase
                // no immediate for anything rejected
                if (kind == k_illegal)
                        fmt = fmt_none;
        end

        ////////////////////////////////////////
        // decoded packet, imm filled in later
        ////////////////////////////////////////

        assign dec.op      = kind;
        assign dec.rd      = cap.inst[11:7];
        assign dec.rs1     = cap.inst[19:15];
        assign dec.rs2     = cap.inst[24:20];
        assign dec.fmt     = fmt;
        assign dec.imm     = '0;
        assign dec.illegal = (kind == k_illegal);

endmodule

// ==== src/inst_capture.sv ====
`timescale 1ns/100ps

module inst_capture (
        input  logic                         clk,
        input  logic                         rst,
        input  logic                         inst_valid,
        input  logic [rv_isa_pkg::xlen-1:0]  inst_pc,
        input  logic [rv_isa_pkg::xlen-1:0]  inst,
        output logic                         cap_valid,
        output decode_pkg::fetch_t           cap
);

        ////////////////////////////////////////
        // input register
        ////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (rst) begin
                        cap_valid <= 1'b0;
                        cap       <= '0;
                end else begin
                        // one cycle behind the strobe
                        cap_valid <= inst_valid;
                        if (inst_valid) begin
                                cap.pc   <= inst_pc;
                                cap.inst <= inst;
                        end
                end
        end

endmodule

// ==== src/decode_pkg.sv ====
package decode_pkg;

        import rv_isa_pkg::*;

        // immediate layout selected by the decoder
        typedef enum logic [2:0] {
                fmt_none,
                fmt_i,
                fmt_s,
                fmt_b,
                fmt_u,
                fmt_j
        } imm_fmt_e;

        // captured word and its pc
        typedef struct packed {
                logic [xlen-1:0] pc;
                logic [xlen-1:0] inst;
        } fetch_t;

        typedef struct packed {
                rv_op_e            op;
                logic [reg_aw-1:0] rd;
                logic [reg_aw-1:0] rs1;
                logic [reg_aw-1:0] rs2;
                imm_fmt_e          fmt;
                logic [xlen-1:0]   imm;
                logic              illegal;
        } decoded_t;

        // packet leaving the stage
        typedef struct packed {
                decoded_t        dec;
                logic [xlen-1:0] pc;
                logic [xlen-1:0] target;
                logic            rd_we;
        } issue_t;

endpackage

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

        ////////////////////////////////////////
        // widths
        ////////////////////////////////////////

        localparam int xlen   = 32;
        localparam int reg_aw = 5;

        ////////////////////////////////////////
        // major opcodes, inst[6:0]
        ////////////////////////////////////////

        typedef enum logic [6:0] {
                op_r      = 7'b0110011,
                op_load   = 7'b0000011,
                op_jalr   = 7'b1100111,
                op_imm    = 7'b0010011,
                op_store  = 7'b0100011,
                op_branch = 7'b1100011,
                op_lui    = 7'b0110111,
                op_auipc  = 7'b0010111,
                op_jal    = 7'b1101111
        } opcode_e;

        ////////////////////////////////////////
        // decoded instruction kinds
        ////////////////////////////////////////

        typedef enum logic [5:0] {
                // R integer
                k_add, k_sub, k_sll, k_slt, k_sltu,
                k_xor, k_srl, k_sra, k_or, k_and,
                // M extension
                k_mul, k_mulh, k_mulhsu, k_mulhu,
                k_div, k_divu, k_rem, k_remu,
                // I arithmetic
                k_addi, k_slti, k_sltiu, k_xori, k_ori,
                k_andi, k_slli, k_srli, k_srai,
                // loads and stores
                k_lb, k_lh, k_lw, k_lbu, k_lhu,
                k_sb, k_sh, k_sw,
                // branches
                k_beq, k_bne, k_blt, k_bge, k_bltu, k_bgeu,
                // upper immediates and jumps
                k_lui, k_auipc, k_jal, k_jalr,
                k_illegal
        } rv_op_e;

endpackage
